// ==== include/usb_ahb_regs.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// usb endpoint register map
// register addresses, status and error bit positions
// and the usb packet id codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef USB_AHB_REGS_SVH
`define USB_AHB_REGS_SVH

// register addresses, data window spans 0 to 3
localparam logic [3:0] REG_ADDR_DATA      = 4'd0;
localparam logic [3:0] REG_ADDR_STATUS    = 4'd4;
localparam logic [3:0] REG_ADDR_ERROR     = 4'd6;
localparam logic [3:0] REG_ADDR_OCCUPANCY = 4'd8;
localparam logic [3:0] REG_ADDR_TX_PACKET = 4'd12;
localparam logic [3:0] REG_ADDR_FLUSH     = 4'd13;

// status register bits
localparam int STAT_BIT_RX_READY  = 0;
localparam int STAT_BIT_IN        = 1;
localparam int STAT_BIT_OUT       = 2;
localparam int STAT_BIT_ACK       = 3;
localparam int STAT_BIT_NAK       = 4;
localparam int STAT_BIT_RX_ACTIVE = 8;
localparam int STAT_BIT_TX_ACTIVE = 9;

// error register bits
localparam int ERR_BIT_RX = 0;
localparam int ERR_BIT_TX = 8;

// packet id codes as sent on the wire
localparam logic [3:0] PID_CODE_OUT   = 4'b0001;
localparam logic [3:0] PID_CODE_IN    = 4'b1001;
localparam logic [3:0] PID_CODE_DATA0 = 4'b0011;
localparam logic [3:0] PID_CODE_ACK   = 4'b0010;
localparam logic [3:0] PID_CODE_NAK   = 4'b1010;
localparam logic [3:0] PID_CODE_STALL = 4'b1110;

`endif

// ==== src/usb_ahb_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// usb ahb slave package
// bus widths, bus and state enums, decoded access and
// usb status structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package usb_ahb_pkg;

    `include "usb_ahb_regs.svh"

    localparam int DATA_W = 32;
    localparam int ADDR_W = 4;

    // ahb transfer type, only NONSEQ starts a transfer here
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [1:0] {
        HSIZE_BYTE = 2'b00,
        HSIZE_HALF = 2'b01,
        HSIZE_WORD = 2'b10,
        HSIZE_BAD  = 2'b11
    } hsize_t;

    // addressed register
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_RX_DATA,
        SEL_STATUS,
        SEL_ERROR,
        SEL_OCCUPANCY,
        SEL_TX_PACKET,
        SEL_FLUSH
    } reg_sel_t;

    typedef enum logic [3:0] {
        PID_NONE  = 4'b0000,
        PID_OUT   = PID_CODE_OUT,
        PID_IN    = PID_CODE_IN,
        PID_DATA0 = PID_CODE_DATA0,
        PID_ACK   = PID_CODE_ACK,
        PID_NAK   = PID_CODE_NAK,
        PID_STALL = PID_CODE_STALL
    } pid_t;

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_RD1,
        FETCH_RD2,
        FETCH_RD3,
        FETCH_RD4
    } fetch_state_t;

    // one decoded bus access
    typedef struct packed {
        logic       valid;
        logic       write;
        logic       err;
        reg_sel_t   sel;
        hsize_t     size;
        logic [1:0] lane;
    } ahb_access_t;

    // protocol side inputs
    typedef struct packed {
        logic rx_data_ready;
        pid_t rx_packet;
        logic rx_transfer_active;
        logic rx_error;
        logic tx_transfer_active;
        logic tx_error;
    } usb_status_t;

endpackage

// ==== src/ahb_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ahb address phase decode
// maps the address to a register, checks size, alignment
// and direction, and holds the access for the data phase
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ahb_decode
(
    input  logic                           clk,
    input  logic                           n_rst,
    input  logic                           hsel,
    input  logic                           hwrite,
    input  usb_ahb_pkg::htrans_t           htrans,
    input  usb_ahb_pkg::hsize_t            hsize,
    input  logic [usb_ahb_pkg::ADDR_W-1:0] haddr,
    input  logic                           hready,
    output usb_ahb_pkg::ahb_access_t       addr_acc,
    output usb_ahb_pkg::ahb_access_t       data_acc
);
    import usb_ahb_pkg::*;

    reg_sel_t          sel;
    logic [ADDR_W-1:0] pair_addr;
    logic              aligned;
    logic              write_ok;

    // register map, status and error are halfword pairs
    always_comb
    begin
        pair_addr = {haddr[ADDR_W-1:1], 1'b0};
        if (haddr < REG_ADDR_STATUS)
            sel = SEL_RX_DATA;
        else if (pair_addr == REG_ADDR_STATUS)
            sel = SEL_STATUS;
        else if (pair_addr == REG_ADDR_ERROR)
            sel = SEL_ERROR;
        else if (haddr == REG_ADDR_OCCUPANCY)
            sel = SEL_OCCUPANCY;
        else if (haddr == REG_ADDR_TX_PACKET)
            sel = SEL_TX_PACKET;
        else if (haddr == REG_ADDR_FLUSH)
            sel = SEL_FLUSH;
        else
            sel = SEL_NONE;
    end

    // halfwords only at 0, 2, 4, 6 and words only at 0
    always_comb
    begin
        case (hsize)
            HSIZE_BYTE:
                aligned = 1'b1;
            HSIZE_HALF:
                aligned = !haddr[0] && ((sel == SEL_RX_DATA) || (sel == SEL_STATUS)
                                        || (sel == SEL_ERROR));
            HSIZE_WORD:
                aligned = (haddr == REG_ADDR_DATA);
            default:
                aligned = 1'b0;
        endcase
    end

    // only the packet and flush controls are writable
    assign write_ok = !hwrite || (sel == SEL_TX_PACKET) || (sel == SEL_FLUSH);

    always_comb
    begin
        addr_acc.valid = hsel && (htrans == HTRANS_NONSEQ) && hready;
        addr_acc.write = hwrite;
        addr_acc.err   = (sel == SEL_NONE) || !aligned || !write_ok;
        addr_acc.sel   = sel;
        addr_acc.size  = hsize;
        addr_acc.lane  = haddr[1:0];
    end

    // data phase copy, empty when no transfer was accepted
    always_ff @(posedge clk, negedge n_rst)
    begin
        if (!n_rst)
            data_acc <= '0;
        else if (addr_acc.valid)
            data_acc <= addr_acc;
        else
            data_acc <= '0;
    end

endmodule

// ==== src/rx_fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive fifo byte fetch
// pulls one, two or four bytes, one per cycle, and packs
// them upward from the low byte lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rx_fetch
(
    input  logic                           clk,
    input  logic                           n_rst,
    input  usb_ahb_pkg::ahb_access_t       addr_acc,
    input  logic [7:0]                     rx_data,
    output logic                           get_rx_data,
    output logic                           busy,
    output logic [usb_ahb_pkg::DATA_W-1:0] rx_word
);
    import usb_ahb_pkg::*;

    fetch_state_t      state;
    fetch_state_t      next_state;
    logic [2:0]        bytes_left;
    logic [2:0]        next_bytes_left;
    logic [DATA_W-1:0] word_q;
    logic              start;

    assign start = addr_acc.valid && !addr_acc.err && !addr_acc.write
                   && (addr_acc.sel == SEL_RX_DATA);

    always_comb
    begin
        next_state      = state;
        next_bytes_left = bytes_left;
        case (state)
            FETCH_IDLE:
            begin
                if (start)
                begin
                    next_state = FETCH_RD1;
                    case (addr_acc.size)
                        HSIZE_HALF: next_bytes_left = 3'd2;
                        HSIZE_WORD: next_bytes_left = 3'd4;
                        default:    next_bytes_left = 3'd1;
                    endcase
                end
            end
            FETCH_RD1:
                next_state = (bytes_left == 3'd1) ? FETCH_IDLE : FETCH_RD2;
            FETCH_RD2:
                next_state = (bytes_left == 3'd1) ? FETCH_IDLE : FETCH_RD3;
            FETCH_RD3:
                next_state = FETCH_RD4;
            default:
                next_state = FETCH_IDLE;
        endcase
        if (state != FETCH_IDLE)
            next_bytes_left = bytes_left - 3'd1;
    end

    always_ff @(posedge clk, negedge n_rst)
    begin
        if (!n_rst)
        begin
            state      <= FETCH_IDLE;
            bytes_left <= '0;
        end
        else
        begin
            state      <= next_state;
            bytes_left <= next_bytes_left;
        end
    end

    // current byte merged into its lane
    always_comb
    begin
        rx_word = word_q;
        case (state)
            FETCH_RD1: rx_word[7:0]   = rx_data;
            FETCH_RD2: rx_word[15:8]  = rx_data;
            FETCH_RD3: rx_word[23:16] = rx_data;
            FETCH_RD4: rx_word[31:24] = rx_data;
            default:   rx_word = word_q;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (start)
            word_q <= '0;
        else if (busy)
            word_q <= rx_word;
    end

    assign busy        = (state != FETCH_IDLE);
    assign get_rx_data = busy;

endmodule

// ==== src/endpoint_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// endpoint registers
// sampled status, error and occupancy, tx packet and flush
// controls, and register read data on its byte lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module endpoint_regs
#(
    parameter int OCC_W = 7
)
(
    input  logic                           clk,
    input  logic                           n_rst,
    input  usb_ahb_pkg::ahb_access_t       addr_acc,
    input  usb_ahb_pkg::ahb_access_t       data_acc,
    input  logic [usb_ahb_pkg::DATA_W-1:0] hwdata,
    input  usb_ahb_pkg::usb_status_t       status_in,
    input  logic [OCC_W-1:0]               buffer_occupancy,
    output logic [usb_ahb_pkg::DATA_W-1:0] reg_rdata,
    output usb_ahb_pkg::pid_t              tx_packet,
    output logic                           clear,
    output logic                           d_mode
);
    import usb_ahb_pkg::*;

    logic [15:0]      status_word;
    logic [15:0]      status_q;
    logic [15:0]      error_word;
    logic [15:0]      error_q;
    logic [OCC_W-1:0] occ_q;
    pid_t             tx_pid_q;
    pid_t             tx_pid_enc;
    logic             flush_q;
    logic             tx_fall;
    logic             wr_tx_packet;
    logic             wr_flush;
    logic [15:0]      half;

    always_comb
    begin
        status_word = '0;
        status_word[STAT_BIT_RX_READY]  = status_in.rx_data_ready;
        status_word[STAT_BIT_IN]        = (status_in.rx_packet == PID_IN);
        status_word[STAT_BIT_OUT]       = (status_in.rx_packet == PID_OUT);
        status_word[STAT_BIT_ACK]       = (status_in.rx_packet == PID_ACK);
        status_word[STAT_BIT_NAK]       = (status_in.rx_packet == PID_NAK);
        status_word[STAT_BIT_RX_ACTIVE] = status_in.rx_transfer_active;
        status_word[STAT_BIT_TX_ACTIVE] = status_in.tx_transfer_active;
        error_word = '0;
        error_word[ERR_BIT_RX] = status_in.rx_error;
        error_word[ERR_BIT_TX] = status_in.tx_error;
    end

    // sampled status holds last cycle's tx active
    assign tx_fall = status_q[STAT_BIT_TX_ACTIVE] && !status_in.tx_transfer_active;

    // command code to packet id
    always_comb
    begin
        case (hwdata)
            DATA_W'(1): tx_pid_enc = PID_DATA0;
            DATA_W'(2): tx_pid_enc = PID_ACK;
            DATA_W'(3): tx_pid_enc = PID_NAK;
            DATA_W'(4): tx_pid_enc = PID_STALL;
            default:    tx_pid_enc = PID_NONE;
        endcase
    end

    assign wr_tx_packet = data_acc.valid && !data_acc.err && data_acc.write
                          && (data_acc.sel == SEL_TX_PACKET);
    assign wr_flush     = data_acc.valid && !data_acc.err && data_acc.write
                          && (data_acc.sel == SEL_FLUSH);

    always_ff @(posedge clk, negedge n_rst)
    begin
        if (!n_rst)
        begin
            status_q <= '0;
            error_q  <= '0;
            occ_q    <= '0;
            tx_pid_q <= PID_NONE;
            flush_q  <= 1'b0;
        end
        else
        begin
            status_q <= status_word;
            error_q  <= error_word;
            occ_q    <= buffer_occupancy;
            // end of transmission clears the packet
            if (tx_fall)
                tx_pid_q <= PID_NONE;
            else if (wr_tx_packet)
                tx_pid_q <= tx_pid_enc;
            // flush ends once the buffer is empty
            if (buffer_occupancy == '0)
                flush_q <= 1'b0;
            else if (wr_flush)
                flush_q <= hwdata[0];
        end
    end

    // odd byte goes to 15:8, even byte to 7:0
    always_comb
    begin
        half = '0;
        case (addr_acc.sel)
            SEL_STATUS:               half = status_q;
            SEL_ERROR:                half = error_q;
            SEL_OCCUPANCY:            half[OCC_W-1:0] = occ_q;
            SEL_TX_PACKET, SEL_FLUSH: half = {7'd0, flush_q, 4'd0, tx_pid_q};
            default:                  half = '0;
        endcase
        reg_rdata = '0;
        if (addr_acc.size == HSIZE_HALF)
            reg_rdata[15:0] = half;
        else if (addr_acc.lane[0])
            reg_rdata[15:8] = half[15:8];
        else
            reg_rdata[7:0] = half[7:0];
    end

    assign tx_packet = tx_pid_q;
    assign clear     = flush_q;
    assign d_mode    = !status_in.rx_transfer_active;

endmodule

// ==== src/read_return.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ahb read return and response
// registers hrdata, stretches the data phase during a fetch
// and drives the two cycle error response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module read_return
(
    input  logic                           clk,
    input  logic                           n_rst,
    input  usb_ahb_pkg::ahb_access_t       addr_acc,
    input  usb_ahb_pkg::ahb_access_t       data_acc,
    input  logic                           busy,
    input  logic [usb_ahb_pkg::DATA_W-1:0] rx_word,
    input  logic [usb_ahb_pkg::DATA_W-1:0] reg_rdata,
    output logic [usb_ahb_pkg::DATA_W-1:0] hrdata,
    output logic                           hready,
    output logic                           hresp
);
    import usb_ahb_pkg::*;

    logic reg_read;
    logic err_first;
    logic err_second;

    // register reads complete in one data cycle
    assign reg_read = addr_acc.valid && !addr_acc.err && !addr_acc.write
                      && (addr_acc.sel != SEL_RX_DATA);

    // first error cycle is the data phase of a failed access
    assign err_first = data_acc.valid && data_acc.err;

    always_ff @(posedge clk, negedge n_rst)
    begin
        if (!n_rst)
        begin
            hrdata     <= '0;
            err_second <= 1'b0;
        end
        else
        begin
            err_second <= err_first;
            if (reg_read)
                hrdata <= reg_rdata;
            // last fetch cycle leaves the complete word
            else if (busy)
                hrdata <= rx_word;
        end
    end

    assign hready = !(busy || err_first);
    assign hresp  = err_first || err_second;

endmodule

// ==== src/usb_ahb_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// usb endpoint ahb-lite slave
// register front end: decode, rx fetch, endpoint registers
// and read return
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module usb_ahb_slave
#(
    parameter int OCC_W = 7
)
(
    input  logic                           clk,
    input  logic                           n_rst,
    input  logic                           hsel,
    input  logic                           hwrite,
    input  usb_ahb_pkg::htrans_t           htrans,
    input  usb_ahb_pkg::hsize_t            hsize,
    input  logic [usb_ahb_pkg::ADDR_W-1:0] haddr,
    input  logic [usb_ahb_pkg::DATA_W-1:0] hwdata,
    output logic [usb_ahb_pkg::DATA_W-1:0] hrdata,
    output logic                           hready,
    output logic                           hresp,
    input  usb_ahb_pkg::usb_status_t       status_in,
    input  logic [7:0]                     rx_data,
    input  logic [OCC_W-1:0]               buffer_occupancy,
    output logic                           get_rx_data,
    output usb_ahb_pkg::pid_t              tx_packet,
    output logic                           clear,
    output logic                           d_mode
);
    import usb_ahb_pkg::*;

    ahb_access_t       addr_acc;
    ahb_access_t       data_acc;
    logic              busy;
    logic [DATA_W-1:0] rx_word;
    logic [DATA_W-1:0] reg_rdata;

    ahb_decode u_decode (
        .clk      (clk),
        .n_rst    (n_rst),
        .hsel     (hsel),
        .hwrite   (hwrite),
        .htrans   (htrans),
        .hsize    (hsize),
        .haddr    (haddr),
        .hready   (hready),
        .addr_acc (addr_acc),
        .data_acc (data_acc)
    );

    rx_fetch u_fetch (
        .clk         (clk),
        .n_rst       (n_rst),
        .addr_acc    (addr_acc),
        .rx_data     (rx_data),
        .get_rx_data (get_rx_data),
        .busy        (busy),
        .rx_word     (rx_word)
    );

    endpoint_regs #(
        .OCC_W (OCC_W)
    ) u_regs (
        .clk              (clk),
        .n_rst            (n_rst),
        .addr_acc         (addr_acc),
        .data_acc         (data_acc),
        .hwdata           (hwdata),
        .status_in        (status_in),
        .buffer_occupancy (buffer_occupancy),
        .reg_rdata        (reg_rdata),
        .tx_packet        (tx_packet),
        .clear            (clear),
        .d_mode           (d_mode)
    );

    read_return u_return (
        .clk       (clk),
        .n_rst     (n_rst),
        .addr_acc  (addr_acc),
        .data_acc  (data_acc),
        .busy      (busy),
        .rx_word   (rx_word),
        .reg_rdata (reg_rdata),
        .hrdata    (hrdata),
        .hready    (hready),
        .hresp     (hresp)
    );

endmodule

// ==== dv/tb_usb_ahb_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// usb ahb slave testbench
// directed bus reads and writes against the register map,
// with a receive fifo model and typed compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_usb_ahb_slave;
    import usb_ahb_pkg::*;

    localparam int OCC_W          = 7;
    localparam int TIMEOUT_CYCLES = 3000;

    logic              clk;
    logic              n_rst;
    logic              hsel;
    logic              hwrite;
    htrans_t           htrans;
    hsize_t            hsize;
    logic [ADDR_W-1:0] haddr;
    logic [DATA_W-1:0] hwdata;
    logic [DATA_W-1:0] hrdata;
    logic              hready;
    logic              hresp;
    usb_status_t       status_in;
    logic [7:0]        rx_data;
    logic [OCC_W-1:0]  buffer_occupancy;
    logic              get_rx_data;
    pid_t              tx_packet;
    logic              clear;
    logic              d_mode;

    integer            seed        = 8876;
    int                cycle_count = 0;
    int                get_count   = 0;
    logic              pop_pending = 1'b0;
    logic [7:0]        sent_bytes[$];

    usb_ahb_slave #(
        .OCC_W (OCC_W)
    ) UUT (
        .clk              (clk),
        .n_rst            (n_rst),
        .hsel             (hsel),
        .hwrite           (hwrite),
        .htrans           (htrans),
        .hsize            (hsize),
        .haddr            (haddr),
        .hwdata           (hwdata),
        .hrdata           (hrdata),
        .hready           (hready),
        .hresp            (hresp),
        .status_in        (status_in),
        .rx_data          (rx_data),
        .buffer_occupancy (buffer_occupancy),
        .get_rx_data      (get_rx_data),
        .tx_packet        (tx_packet),
        .clear            (clear),
        .d_mode           (d_mode)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Testbench failed");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // fetch strobes sampled mid cycle
    always @(negedge clk)
    begin
        pop_pending <= get_rx_data;
        if (get_rx_data)
            get_count <= get_count + 1;
    end

    // rx fifo model replaces its head byte after each strobe
    initial
    begin
        rx_data = 8'($random(seed));
        forever
        begin
            @(posedge clk);
            #1;
            if (pop_pending)
            begin
                sent_bytes.push_back(rx_data);
                rx_data = 8'($random(seed));
            end
        end
    end

    task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_pid(input string name, input pid_t expected, input pid_t actual);
        if (actual !== expected)
        begin
            $display("error %s expected %s (%h) actual %s (%h)", name, expected.name(),
                     expected, actual.name(), actual);
            $display("Testbench failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("error %s expected %b actual %b", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [15:0] expected_status(input usb_status_t s);
        logic [15:0] w;
        w = (16'(s.rx_data_ready) << STAT_BIT_RX_READY)
            | (16'(s.rx_transfer_active) << STAT_BIT_RX_ACTIVE)
            | (16'(s.tx_transfer_active) << STAT_BIT_TX_ACTIVE);
        // one flag for the received token or handshake
        case (s.rx_packet)
            PID_IN:  w = w | (16'd1 << STAT_BIT_IN);
            PID_OUT: w = w | (16'd1 << STAT_BIT_OUT);
            PID_ACK: w = w | (16'd1 << STAT_BIT_ACK);
            PID_NAK: w = w | (16'd1 << STAT_BIT_NAK);
            default: ;
        endcase
        return w;
    endfunction

    function automatic logic [15:0] expected_error(input usb_status_t s);
        return (16'(s.rx_error) << ERR_BIT_RX) | (16'(s.tx_error) << ERR_BIT_TX);
    endfunction

    function automatic pid_t expected_pid(input int code);
        case (code)
            1:       return PID_DATA0;
            2:       return PID_ACK;
            3:       return PID_NAK;
            4:       return PID_STALL;
            default: return PID_NONE;
        endcase
    endfunction

    // odd byte in 15:8, even byte in 7:0, halfword in 15:0
    function automatic logic [DATA_W-1:0] on_lane(input logic [15:0] value, input hsize_t size,
                                                  input logic [ADDR_W-1:0] addr);
        if (size == HSIZE_HALF)
            return DATA_W'(value);
        if (addr[0])
            return DATA_W'(value[15:8]) << 8;
        return DATA_W'(value[7:0]);
    endfunction

    function automatic usb_status_t make_status(input logic ready, input pid_t pid,
                                                input logic rx_act, input logic rx_err,
                                                input logic tx_act, input logic tx_err);
        return '{rx_data_ready: ready, rx_packet: pid, rx_transfer_active: rx_act,
                 rx_error: rx_err, tx_transfer_active: tx_act, tx_error: tx_err};
    endfunction

    // inputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic addr_phase(input logic write, input hsize_t size,
                              input logic [ADDR_W-1:0] addr);
        while (!hready)
        begin
            next_cycle();
        end
        hsel   = 1'b1;
        htrans = HTRANS_NONSEQ;
        hwrite = write;
        hsize  = size;
        haddr  = addr;
        next_cycle();
        hsel   = 1'b0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
    endtask

    task automatic ahb_read(input hsize_t size, input logic [ADDR_W-1:0] addr,
                            output logic [DATA_W-1:0] data, output int waits);
        waits = 0;
        addr_phase(1'b0, size, addr);
        while (!hready)
        begin
            waits++;
            next_cycle();
        end
        data = hrdata;
        next_cycle();
    endtask

    task automatic ahb_write(input hsize_t size, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
        addr_phase(1'b1, size, addr);
        hwdata = data;
        while (!hready)
        begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic read_and_check(input string name, input hsize_t size,
                                  input logic [ADDR_W-1:0] addr, input logic [15:0] value);
        logic [DATA_W-1:0] data;
        int                waits;
        ahb_read(size, addr, data, waits);
        check_word({name, " wait cycles"}, '0, DATA_W'(waits));
        check_word(name, on_lane(value, size, addr), data);
    endtask

    task automatic status_reads(input string name, input usb_status_t s,
                                input logic [OCC_W-1:0] occ);
        logic [15:0] stat;
        logic [15:0] errs;
        status_in        = s;
        buffer_occupancy = occ;
        stat             = expected_status(s);
        errs             = expected_error(s);
        next_cycle();
        check_bit({name, " d_mode"}, !s.rx_transfer_active, d_mode);
        next_cycle();
        read_and_check({name, " status byte 4"}, HSIZE_BYTE, 4'd4, stat);
        read_and_check({name, " status byte 5"}, HSIZE_BYTE, 4'd5, stat);
        read_and_check({name, " status half"}, HSIZE_HALF, REG_ADDR_STATUS, stat);
        read_and_check({name, " error byte 6"}, HSIZE_BYTE, 4'd6, errs);
        read_and_check({name, " error byte 7"}, HSIZE_BYTE, 4'd7, errs);
        read_and_check({name, " error half"}, HSIZE_HALF, REG_ADDR_ERROR, errs);
        read_and_check({name, " occupancy"}, HSIZE_BYTE, REG_ADDR_OCCUPANCY, 16'(occ));
    endtask

    task automatic packet_control();
        logic [DATA_W-1:0] data;
        int                waits;
        int                code;
        pid_t              pid;
        for (code = 1; code <= 5; code++)
        begin
            pid = expected_pid(code);
            ahb_write(HSIZE_BYTE, REG_ADDR_TX_PACKET, DATA_W'(code));
            check_pid($sformatf("tx packet code %0d", code), pid, tx_packet);
            ahb_read(HSIZE_BYTE, REG_ADDR_TX_PACKET, data, waits);
            check_word($sformatf("tx packet readback %0d", code), DATA_W'(pid), data);
        end
        // end of transmission clears the packet one cycle later
        ahb_write(HSIZE_BYTE, REG_ADDR_TX_PACKET, 32'd3);
        status_in.tx_transfer_active = 1'b1;
        next_cycle();
        next_cycle();
        check_pid("tx packet during tx", PID_NAK, tx_packet);
        status_in.tx_transfer_active = 1'b0;
        check_pid("tx packet at tx fall", PID_NAK, tx_packet);
        next_cycle();
        check_pid("tx packet after tx fall", PID_NONE, tx_packet);
        // flush holds until the buffer drains
        buffer_occupancy = 7'd20;
        next_cycle();
        ahb_write(HSIZE_BYTE, REG_ADDR_FLUSH, 32'd1);
        check_bit("flush set", 1'b1, clear);
        ahb_read(HSIZE_BYTE, REG_ADDR_FLUSH, data, waits);
        check_word("flush readback", 32'h0000_0100, data);
        buffer_occupancy = '0;
        check_bit("flush held", 1'b1, clear);
        next_cycle();
        check_bit("flush cleared", 1'b0, clear);
    endtask

    task automatic rx_read(input string name, input hsize_t size,
                           input logic [ADDR_W-1:0] addr, input int nbytes);
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] expected;
        int                waits;
        int                gets_before;
        int                first;
        int                i;
        gets_before = get_count;
        first       = sent_bytes.size();
        ahb_read(size, addr, data, waits);
        check_word({name, " get_rx_data cycles"}, DATA_W'(nbytes),
                   DATA_W'(get_count - gets_before));
        check_word({name, " wait cycles"}, DATA_W'(nbytes), DATA_W'(waits));
        check_word({name, " bytes sent"}, DATA_W'(nbytes),
                   DATA_W'(sent_bytes.size() - first));
        expected = '0;
        for (i = 0; i < nbytes; i++)
        begin
            expected[8*i +: 8] = sent_bytes[first + i];
        end
        check_word({name, " data"}, expected, data);
    endtask

    task automatic error_access(input string name, input logic write, input hsize_t size,
                                input logic [ADDR_W-1:0] addr);
        int   gets_before;
        pid_t pid_before;
        gets_before = get_count;
        pid_before  = tx_packet;
        addr_phase(write, size, addr);
        // would encode ACK if the write got through
        hwdata = 32'd2;
        check_bit({name, " hresp cycle 1"}, 1'b1, hresp);
        check_bit({name, " hready cycle 1"}, 1'b0, hready);
        check_bit({name, " get_rx_data cycle 1"}, 1'b0, get_rx_data);
        next_cycle();
        check_bit({name, " hresp cycle 2"}, 1'b1, hresp);
        check_bit({name, " hready cycle 2"}, 1'b1, hready);
        check_bit({name, " get_rx_data cycle 2"}, 1'b0, get_rx_data);
        next_cycle();
        hwdata = '0;
        check_bit({name, " hresp after"}, 1'b0, hresp);
        check_word({name, " get_rx_data cycles"}, '0, DATA_W'(get_count - gets_before));
        check_pid({name, " tx packet"}, pid_before, tx_packet);
    endtask

    initial
    begin
        n_rst            = 1'b0;
        hsel             = 1'b0;
        hwrite           = 1'b0;
        htrans           = HTRANS_IDLE;
        hsize            = HSIZE_BYTE;
        haddr            = '0;
        hwdata           = '0;
        status_in        = '0;
        buffer_occupancy = '0;
        repeat (16) @(posedge clk);
        #1;
        n_rst = 1'b1;
        next_cycle();

        check_bit("reset hready", 1'b1, hready);
        check_bit("reset hresp", 1'b0, hresp);
        check_bit("reset get_rx_data", 1'b0, get_rx_data);
        check_bit("reset clear", 1'b0, clear);
        check_pid("reset tx packet", PID_NONE, tx_packet);
        check_word("reset hrdata", '0, hrdata);

        status_reads("status in", make_status(1, PID_IN, 1, 1, 0, 0), 7'd37);
        status_reads("status ack", make_status(0, PID_ACK, 0, 0, 1, 1), 7'd100);
        status_reads("status out", make_status(1, PID_OUT, 0, 1, 0, 0), 7'd1);
        status_reads("status nak", make_status(0, PID_NAK, 1, 0, 0, 1), 7'd127);
        status_in = '0;
        next_cycle();

        packet_control();

        rx_read("rx byte 0", HSIZE_BYTE, 4'd0, 1);
        rx_read("rx byte 3", HSIZE_BYTE, 4'd3, 1);
        rx_read("rx half 0", HSIZE_HALF, 4'd0, 2);
        rx_read("rx half 2", HSIZE_HALF, 4'd2, 2);
        rx_read("rx word", HSIZE_WORD, 4'd0, 4);

        ahb_write(HSIZE_BYTE, REG_ADDR_TX_PACKET, 32'd4);
        check_pid("tx packet before errors", PID_STALL, tx_packet);
        error_access("unmapped read", 1'b0, HSIZE_BYTE, 4'd10);
        error_access("illegal size read", 1'b0, HSIZE_BAD, REG_ADDR_STATUS);
        error_access("status write", 1'b1, HSIZE_BYTE, REG_ADDR_STATUS);
        error_access("misaligned half", 1'b0, HSIZE_HALF, 4'd1);
        error_access("misaligned word", 1'b0, HSIZE_WORD, 4'd4);
        error_access("data window write", 1'b1, HSIZE_BYTE, REG_ADDR_DATA);
        error_access("illegal size write", 1'b1, HSIZE_BAD, REG_ADDR_TX_PACKET);

        next_cycle();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
src/usb_ahb_pkg.sv
src/ahb_decode.sv
src/rx_fetch.sv
src/endpoint_regs.sv
src/read_return.sv
src/usb_ahb_slave.sv
dv/tb_usb_ahb_slave.sv

// ==== Makefile ====
# Verilator build and run of the usb ahb slave testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module tb_usb_ahb_slave -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep "Testbench passed" > /dev/null

clean:
	rm -rf obj_dir
